//--- sched_cfg.svh
// ---------------------------------------------------------------------
// Port, core and slot counts of the packet scheduler
// Stream data width and the host register map
// ---------------------------------------------------------------------
`ifndef SCHED_CFG_SVH
`define SCHED_CFG_SVH

`define SCHED_IF_COUNT   3
`define SCHED_CORE_COUNT 8
`define SCHED_SLOT_COUNT 16
`define SCHED_DATA_WIDTH 64

// Wishbone word addresses
`define SCHED_REG_ENABLE    4'd0
`define SCHED_REG_INCOME    4'd1
`define SCHED_REG_FLUSH     4'd2
`define SCHED_REG_PORT_BASE 4'd4
`define SCHED_REG_CORE_BASE 4'd8

`define SCHED_BAD_READ 32'hFEFEFEFE

`endif

//--- sched_pkg.sv
// ---------------------------------------------------------------------
// Shared types of the packet scheduler
// Core numbers, slots, descriptors, masks, port states and stream words
// ---------------------------------------------------------------------
`default_nettype none

`include "sched_cfg.svh"

package sched_pkg;

  typedef logic [$clog2(`SCHED_CORE_COUNT)-1:0]   core_id_t;
  // Slot 0 means no slot
  typedef logic [$clog2(`SCHED_SLOT_COUNT+1)-1:0] slot_t;

  // Stream destination
  typedef struct packed {
    core_id_t core;
    slot_t    slot;
  } desc_t;

  typedef logic [`SCHED_CORE_COUNT-1:0] core_mask_t;
  typedef logic [`SCHED_IF_COUNT-1:0]   port_mask_t;

  typedef enum logic [1:0] {
    STALL = 2'd0,
    FIRST = 2'd1,
    WAIT  = 2'd2,
    MID   = 2'd3
  } port_state_e;

  typedef logic [`SCHED_DATA_WIDTH-1:0]   data_t;
  typedef logic [`SCHED_DATA_WIDTH/8-1:0] keep_t;

endpackage

`default_nettype wire

//--- sched_if.sv
// ---------------------------------------------------------------------
// Internal buses of the scheduler
// slot_offer_if carries the selected head slot to the dispatcher
// desc_load_if carries port requests and descriptor loads
// ---------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "sched_cfg.svh"

interface slot_offer_if import sched_pkg::*; ();
  logic     offer_valid;
  core_id_t offer_core;
  slot_t    offer_slot;
  logic     offer_pop;

  modport pool (
    output offer_valid, offer_core, offer_slot,
    input  offer_pop
  );

  modport dispatch (
    input  offer_valid, offer_core, offer_slot,
    output offer_pop
  );
endinterface

interface desc_load_if import sched_pkg::*; ();
  port_mask_t                          req;
  logic                                load_valid;
  logic [$clog2(`SCHED_IF_COUNT)-1:0]  load_port;
  desc_t                               load_desc;

  modport tracker (
    output req,
    input  load_valid, load_port, load_desc
  );

  modport dispatch (
    input  req,
    output load_valid, load_port, load_desc
  );
endinterface

`default_nettype wire

//--- slot_keeper.sv
// ---------------------------------------------------------------------
// Free-slot queue of one core
// Circular buffer with init, return, pop and flush
// ---------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "sched_cfg.svh"

module slot_keeper import sched_pkg::*; (
  input  logic  clk,
  input  logic  rst_r,
  input  logic  flush,
  input  logic  init_valid,
  input  slot_t init_count,
  input  logic  push_valid,
  input  slot_t push_slot,
  input  logic  pop,
  output slot_t head,
  output slot_t count
);

  localparam int PTR_W = $clog2(`SCHED_SLOT_COUNT);

  slot_t            mem [0:`SCHED_SLOT_COUNT-1];
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;
  slot_t            init_n;
  logic             do_push;
  logic             do_pop;

  // Counts above the depth are clamped
  assign init_n  = (init_count > `SCHED_SLOT_COUNT) ? slot_t'(`SCHED_SLOT_COUNT) : init_count;
  assign do_push = push_valid && (count != slot_t'(`SCHED_SLOT_COUNT));
  assign do_pop  = pop && (count != '0);
  assign head    = (count != '0) ? mem[rd_ptr] : '0;

  // Init lays out slots 1 to n from entry 0
  always_ff @(posedge clk) begin
    if (init_valid) begin
      for (int i = 0; i < `SCHED_SLOT_COUNT; i++) begin
        mem[i] <= slot_t'(i + 1);
      end
    end else if (do_push) begin
      mem[wr_ptr] <= push_slot;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r || flush) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else if (init_valid) begin
      rd_ptr <= '0;
      wr_ptr <= init_n[PTR_W-1:0];
      count  <= init_n;
    end else begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- slot_pool.sv
// ---------------------------------------------------------------------
// Slot pools of all cores
// Slot message decode and selection of the core with most free slots
// ---------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "sched_cfg.svh"

module slot_pool import sched_pkg::*; (
  input  logic                          clk,
  input  logic                          rst_r,
  input  logic                          slot_msg_valid,
  input  logic                          slot_msg_init,
  input  core_id_t                      slot_msg_core,
  input  slot_t                         slot_msg_slot,
  input  core_mask_t                    income_cores,
  input  core_mask_t                    flush_cores,
  slot_offer_if.pool                    offer,
  output slot_t [`SCHED_CORE_COUNT-1:0] slot_counts
);

  logic                          msg_valid_r;
  logic                          msg_init_r;
  core_id_t                      msg_core_r;
  slot_t                         msg_slot_r;
  slot_t [`SCHED_CORE_COUNT-1:0] heads;
  core_id_t                      sel_core;
  slot_t                         sel_count;

  // Messages are registered once before reaching the queues
  always_ff @(posedge clk) begin
    if (rst_r)
      msg_valid_r <= 1'b0;
    else
      msg_valid_r <= slot_msg_valid;
  end

  always_ff @(posedge clk) begin
    msg_init_r <= slot_msg_init;
    msg_core_r <= slot_msg_core;
    msg_slot_r <= slot_msg_slot;
  end

  for (genvar i = 0; i < `SCHED_CORE_COUNT; i++) begin : g_core
    slot_keeper u_keeper (
      .clk        (clk),
      .rst_r      (rst_r),
      .flush      (flush_cores[i]),
      .init_valid (msg_valid_r && msg_init_r && (msg_core_r == core_id_t'(i))),
      .init_count (msg_slot_r),
      .push_valid (msg_valid_r && !msg_init_r && (msg_core_r == core_id_t'(i))),
      .push_slot  (msg_slot_r),
      .pop        (offer.offer_pop && offer.offer_valid && (sel_core == core_id_t'(i))),
      .head       (heads[i]),
      .count      (slot_counts[i])
    );
  end

  // Strict compare keeps the lowest index on a tie
  always_comb begin
    sel_core  = '0;
    sel_count = '0;
    for (int i = 0; i < `SCHED_CORE_COUNT; i++) begin
      if (income_cores[i] && (slot_counts[i] > sel_count)) begin
        sel_core  = core_id_t'(i);
        sel_count = slot_counts[i];
      end
    end
  end

  assign offer.offer_valid = (sel_count != '0);
  assign offer.offer_core  = sel_core;
  assign offer.offer_slot  = heads[sel_core];

endmodule

`default_nettype wire

//--- port_tracker.sv
// ---------------------------------------------------------------------
// Per-port descriptor state machines
// Stamping and gating of the receive streams
// ---------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "sched_cfg.svh"

module port_tracker import sched_pkg::*; (
  input  logic                              clk,
  input  logic                              rst_r,
  input  data_t [`SCHED_IF_COUNT-1:0]       rx_tdata,
  input  keep_t [`SCHED_IF_COUNT-1:0]       rx_tkeep,
  input  port_mask_t                        rx_tvalid,
  output port_mask_t                        rx_tready,
  input  port_mask_t                        rx_tlast,
  output data_t [`SCHED_IF_COUNT-1:0]       data_tdata,
  output keep_t [`SCHED_IF_COUNT-1:0]       data_tkeep,
  output desc_t [`SCHED_IF_COUNT-1:0]       data_tdest,
  output port_mask_t                        data_tvalid,
  input  port_mask_t                        data_tready,
  output port_mask_t                        data_tlast,
  desc_load_if.tracker                      load,
  output port_state_e [`SCHED_IF_COUNT-1:0] port_states,
  output desc_t [`SCHED_IF_COUNT-1:0]       port_descs
);

  port_state_e [`SCHED_IF_COUNT-1:0] state;
  desc_t [`SCHED_IF_COUNT-1:0]       wait_desc;
  desc_t [`SCHED_IF_COUNT-1:0]       pkt_desc;
  port_mask_t                        not_stall;
  port_mask_t                        accepted;
  port_mask_t                        last_beat;
  port_mask_t                        loaded;
  port_mask_t                        req;

  always_comb begin
    for (int i = 0; i < `SCHED_IF_COUNT; i++) begin
      not_stall[i]  = (state[i] != STALL);
      loaded[i]     = load.load_valid && (load.load_port == i);
      req[i]        = (state[i] == STALL) || (state[i] == WAIT) ||
                      ((state[i] == FIRST) && accepted[i]);
      // First beat carries the fresh descriptor
      data_tdest[i] = (state[i] == FIRST) ? wait_desc[i] : pkt_desc[i];
    end
  end

  // Stream passes through untouched unless the port is stalled
  assign rx_tready   = data_tready & not_stall;
  assign data_tvalid = rx_tvalid & not_stall;
  assign data_tdata  = rx_tdata;
  assign data_tkeep  = rx_tkeep;
  assign data_tlast  = rx_tlast;
  assign accepted    = rx_tvalid & rx_tready;
  assign last_beat   = accepted & rx_tlast;
  assign load.req    = req;
  assign port_states = state;
  assign port_descs  = wait_desc;

  always_ff @(posedge clk) begin
    for (int i = 0; i < `SCHED_IF_COUNT; i++) begin
      if (rst_r) begin
        state[i] <= STALL;
      end else begin
        case (state[i])
          STALL: if (loaded[i]) state[i] <= FIRST;
          // A load during the first beat acts as a load in WAIT
          FIRST, WAIT: begin
            if (state[i] == WAIT || accepted[i]) begin
              if (loaded[i])
                state[i] <= last_beat[i] ? FIRST : MID;
              else if (last_beat[i])
                state[i] <= STALL;
              else
                state[i] <= WAIT;
            end
          end
          MID:   if (last_beat[i]) state[i] <= FIRST;
          default: state[i] <= STALL;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < `SCHED_IF_COUNT; i++) begin
      if (rst_r)
        wait_desc[i] <= '0;
      else if (loaded[i])
        wait_desc[i] <= load.load_desc;
      // Packet keeps its destination once the first beat is taken
      if ((state[i] == FIRST) && accepted[i])
        pkt_desc[i] <= wait_desc[i];
    end
  end

endmodule

`default_nettype wire

//--- desc_dispatch.sv
// ---------------------------------------------------------------------
// Round-robin pairing of port requests with the offered slot
// ---------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "sched_cfg.svh"

module desc_dispatch import sched_pkg::*; (
  input  logic           clk,
  input  logic           rst_r,
  slot_offer_if.dispatch offer,
  desc_load_if.dispatch  load
);

  localparam int PORT_W = $clog2(`SCHED_IF_COUNT);

  logic [PORT_W-1:0] rr_ptr;
  logic [PORT_W-1:0] winner;
  logic              found;
  logic              grant;

  // First requester at or after the pointer
  always_comb begin
    int idx;
    found  = 1'b0;
    winner = '0;
    for (int k = 0; k < `SCHED_IF_COUNT; k++) begin
      idx = (int'(rr_ptr) + k) % `SCHED_IF_COUNT;
      if (!found && load.req[idx]) begin
        found  = 1'b1;
        winner = PORT_W'(idx);
      end
    end
  end

  assign grant           = found && offer.offer_valid;
  assign load.load_valid = grant;
  assign load.load_port  = winner;
  assign load.load_desc  = '{core: offer.offer_core, slot: offer.offer_slot};
  assign offer.offer_pop = grant;

  always_ff @(posedge clk) begin
    if (rst_r)
      rr_ptr <= '0;
    else if (grant)
      rr_ptr <= (winner == PORT_W'(`SCHED_IF_COUNT - 1)) ? '0 : winner + 1'b1;
  end

endmodule

`default_nettype wire

//--- host_regs.sv
// ---------------------------------------------------------------------
// Wishbone classic slave for scheduler control and status
// Core masks, flush pulses, port states and slot counts
// ---------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "sched_cfg.svh"

module host_regs import sched_pkg::*; (
  input  logic                              clk,
  input  logic                              rst_r,
  input  logic                              wb_cyc,
  input  logic                              wb_stb,
  input  logic                              wb_we,
  input  logic [3:0]                        wb_adr,
  input  logic [31:0]                       wb_dat_i,
  output logic [31:0]                       wb_dat_o,
  output logic                              wb_ack,
  output core_mask_t                        enabled_cores,
  output core_mask_t                        income_cores,
  output core_mask_t                        flush_cores,
  input  slot_t [`SCHED_CORE_COUNT-1:0]     slot_counts,
  input  port_state_e [`SCHED_IF_COUNT-1:0] port_states,
  input  desc_t [`SCHED_IF_COUNT-1:0]       port_descs
);

  logic        access;
  logic [31:0] rd_data;
  logic [3:0]  port_idx;
  logic [3:0]  core_idx;
  core_mask_t  wr_mask;

  // One access per strobe, ack drops for a cycle in between
  assign access   = wb_cyc && wb_stb && !wb_ack;
  assign port_idx = wb_adr - `SCHED_REG_PORT_BASE;
  assign core_idx = wb_adr - `SCHED_REG_CORE_BASE;
  assign wr_mask  = wb_dat_i[`SCHED_CORE_COUNT-1:0];

  always_comb begin
    rd_data = `SCHED_BAD_READ;
    if (wb_adr == `SCHED_REG_ENABLE)
      rd_data = 32'(enabled_cores);
    else if (wb_adr == `SCHED_REG_INCOME)
      rd_data = 32'(income_cores);
    else if ((wb_adr >= `SCHED_REG_PORT_BASE) && (port_idx < `SCHED_IF_COUNT))
      rd_data = 32'({port_states[port_idx], port_descs[port_idx]});
    else if ((wb_adr >= `SCHED_REG_CORE_BASE) && (core_idx < `SCHED_CORE_COUNT))
      rd_data = 32'(slot_counts[core_idx]);
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      wb_ack        <= 1'b0;
      enabled_cores <= '0;
      income_cores  <= '0;
      flush_cores   <= '0;
    end else begin
      wb_ack      <= access;
      flush_cores <= '0;
      if (access && wb_we) begin
        case (wb_adr)
          // Disabled cores drop out of the income set
          `SCHED_REG_ENABLE: begin
            enabled_cores <= wr_mask;
            income_cores  <= income_cores & wr_mask;
          end
          `SCHED_REG_INCOME: income_cores <= wr_mask & enabled_cores;
          `SCHED_REG_FLUSH:  flush_cores  <= wr_mask;
          default:           flush_cores  <= '0;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (access)
      wb_dat_o <= rd_data;
  end

endmodule

`default_nettype wire

//--- sched_top.sv
// ---------------------------------------------------------------------
// Packet scheduler top level
// Slot pools, port trackers, dispatcher and host registers
// ---------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "sched_cfg.svh"

module sched_top import sched_pkg::*; (
  input  logic                        clk,
  input  logic                        rst_r,
  input  data_t [`SCHED_IF_COUNT-1:0] rx_tdata,
  input  keep_t [`SCHED_IF_COUNT-1:0] rx_tkeep,
  input  port_mask_t                  rx_tvalid,
  output port_mask_t                  rx_tready,
  input  port_mask_t                  rx_tlast,
  output data_t [`SCHED_IF_COUNT-1:0] data_tdata,
  output keep_t [`SCHED_IF_COUNT-1:0] data_tkeep,
  output desc_t [`SCHED_IF_COUNT-1:0] data_tdest,
  output port_mask_t                  data_tvalid,
  input  port_mask_t                  data_tready,
  output port_mask_t                  data_tlast,
  input  logic                        slot_msg_valid,
  input  logic                        slot_msg_init,
  input  core_id_t                    slot_msg_core,
  input  slot_t                       slot_msg_slot,
  input  logic                        wb_cyc,
  input  logic                        wb_stb,
  input  logic                        wb_we,
  input  logic [3:0]                  wb_adr,
  input  logic [31:0]                 wb_dat_i,
  output logic [31:0]                 wb_dat_o,
  output logic                        wb_ack
);

  core_mask_t                        income_cores;
  core_mask_t                        flush_cores;
  slot_t [`SCHED_CORE_COUNT-1:0]     slot_counts;
  port_state_e [`SCHED_IF_COUNT-1:0] port_states;
  desc_t [`SCHED_IF_COUNT-1:0]       port_descs;

  slot_offer_if offer_bus ();
  desc_load_if  load_bus ();

  slot_pool u_slot_pool (
    .clk            (clk),
    .rst_r          (rst_r),
    .slot_msg_valid (slot_msg_valid),
    .slot_msg_init  (slot_msg_init),
    .slot_msg_core  (slot_msg_core),
    .slot_msg_slot  (slot_msg_slot),
    .income_cores   (income_cores),
    .flush_cores    (flush_cores),
    .offer          (offer_bus),
    .slot_counts    (slot_counts)
  );

  port_tracker u_port_tracker (
    .clk         (clk),
    .rst_r       (rst_r),
    .rx_tdata    (rx_tdata),
    .rx_tkeep    (rx_tkeep),
    .rx_tvalid   (rx_tvalid),
    .rx_tready   (rx_tready),
    .rx_tlast    (rx_tlast),
    .data_tdata  (data_tdata),
    .data_tkeep  (data_tkeep),
    .data_tdest  (data_tdest),
    .data_tvalid (data_tvalid),
    .data_tready (data_tready),
    .data_tlast  (data_tlast),
    .load        (load_bus),
    .port_states (port_states),
    .port_descs  (port_descs)
  );

  desc_dispatch u_desc_dispatch (
    .clk   (clk),
    .rst_r (rst_r),
    .offer (offer_bus),
    .load  (load_bus)
  );

  // Enable mask is only needed inside the register block
  host_regs u_host_regs (
    .clk           (clk),
    .rst_r         (rst_r),
    .wb_cyc        (wb_cyc),
    .wb_stb        (wb_stb),
    .wb_we         (wb_we),
    .wb_adr        (wb_adr),
    .wb_dat_i      (wb_dat_i),
    .wb_dat_o      (wb_dat_o),
    .wb_ack        (wb_ack),
    .enabled_cores (),
    .income_cores  (income_cores),
    .flush_cores   (flush_cores),
    .slot_counts   (slot_counts),
    .port_states   (port_states),
    .port_descs    (port_descs)
  );

endmodule

`default_nettype wire

//--- tb_sched_top.sv
// ----------------------------------------------------------------------
// Self-checking testbench for the packet scheduler top level
// Table of Wishbone, slot message and packet steps applied in a loop
// Beat monitor, value check and bounded handshake waits
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "sched_cfg.svh"

module tb_sched_top import sched_pkg::*; ();

  localparam int ACK_LIMIT  = 16;
  localparam int BEAT_LIMIT = 50;
  localparam int ST_STALL   = 0;
  localparam int ST_FIRST   = 1;

  typedef enum int {WB_WRITE, WB_READ, MSG_INIT, MSG_RETURN, PACKET} step_kind_e;

  // arg is address, core or port; val is write data, slot or stall cycles
  typedef struct {
    step_kind_e  kind;
    int          arg;
    logic [31:0] val;
    logic [31:0] exp;
  } step_t;

  logic                        clk;
  logic                        rst_r;
  data_t [`SCHED_IF_COUNT-1:0] rx_tdata;
  keep_t [`SCHED_IF_COUNT-1:0] rx_tkeep;
  port_mask_t                  rx_tvalid;
  port_mask_t                  rx_tready;
  port_mask_t                  rx_tlast;
  data_t [`SCHED_IF_COUNT-1:0] data_tdata;
  keep_t [`SCHED_IF_COUNT-1:0] data_tkeep;
  desc_t [`SCHED_IF_COUNT-1:0] data_tdest;
  port_mask_t                  data_tvalid;
  port_mask_t                  data_tready;
  port_mask_t                  data_tlast;
  logic                        slot_msg_valid;
  logic                        slot_msg_init;
  core_id_t                    slot_msg_core;
  slot_t                       slot_msg_slot;
  logic                        wb_cyc;
  logic                        wb_stb;
  logic                        wb_we;
  logic [3:0]                  wb_adr;
  logic [31:0]                 wb_dat_i;
  logic [31:0]                 wb_dat_o;
  logic                        wb_ack;

  step_t       steps[$];
  int          mismatches;
  int          timeouts;
  int          beats;
  logic [31:0] rdata;

  sched_top dut (.*);

  always #4 clk = ~clk;

  // Each transfer on the output side counted once
  always @(negedge clk) begin
    if (!rst_r)
      beats <= beats + $countones(data_tvalid & data_tready);
  end

  task automatic check_equal(input logic [63:0] got, input logic [63:0] exp,
                             input string what);
    if (got !== exp) begin
      $display("error at time %0t: %s, got %0h expected %0h", $time, what, got, exp);
      mismatches++;
    end
  endtask

  // Descriptor holds core then slot in 3 + 5 bits
  function automatic logic [31:0] desc_word(int core, int slot);
    return (core << 5) | slot;
  endfunction

  function automatic logic [31:0] port_word(int state, int core, int slot);
    return (state << 8) | desc_word(core, slot);
  endfunction

  function automatic void add_step(step_kind_e kind, int arg, logic [31:0] val,
                                   logic [31:0] exp);
    step_t s;
    s = '{kind, arg, val, exp};
    steps.push_back(s);
  endfunction

  task automatic wb_access(input logic we, input logic [3:0] adr, input logic [31:0] wdat,
                           output logic [31:0] rdat);
    int t;
    rdat = '0;
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_i <= wdat;
    t = 0;
    do begin
      @(negedge clk);
      t++;
    end while (!wb_ack && t < ACK_LIMIT);
    if (!wb_ack) begin
      $display("Timeout: no Wishbone acknowledge for address %0d", adr);
      timeouts++;
    end else begin
      rdat = wb_dat_o;
    end
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic send_slot_msg(input logic init, input int core, input int slot);
    @(posedge clk);
    slot_msg_valid <= 1'b1;
    slot_msg_init  <= init;
    slot_msg_core  <= core_id_t'(core);
    slot_msg_slot  <= slot_t'(slot);
    @(posedge clk);
    slot_msg_valid <= 1'b0;
    // Message reaches its queue one edge after the register
    @(posedge clk);
  endtask

  // Single-beat packet that back-pressure may hold first
  task automatic send_packet(input int port, input logic [31:0] exp_dest, input int stall);
    data_t word;
    keep_t keep;
    int    t;
    int    start_beats;
    word = {$urandom, $urandom};
    keep = keep_t'($urandom);
    @(posedge clk);
    start_beats = beats;
    rx_tdata[port]  <= word;
    rx_tkeep[port]  <= keep;
    rx_tvalid[port] <= 1'b1;
    rx_tlast[port]  <= 1'b1;
    if (stall > 0)
      data_tready[port] <= 1'b0;
    repeat (stall) begin
      @(negedge clk);
      check_equal(rx_tready[port], 1'b0, $sformatf("rx_tready held, port %0d", port));
      check_equal(data_tvalid[port], 1'b1, $sformatf("data_tvalid held, port %0d", port));
      check_equal(data_tdata[port], word, $sformatf("data held, port %0d", port));
    end
    if (stall > 0) begin
      @(posedge clk);
      data_tready[port] <= 1'b1;
    end
    t = 0;
    do begin
      @(negedge clk);
      t++;
    end while (!(data_tvalid[port] && data_tready[port]) && t < BEAT_LIMIT);
    if (!(data_tvalid[port] && data_tready[port])) begin
      $display("Timeout: port %0d never accepted its packet", port);
      timeouts++;
    end else begin
      check_equal(data_tdest[port], exp_dest, $sformatf("tdest on port %0d", port));
      check_equal(data_tdata[port], word, $sformatf("tdata on port %0d", port));
      check_equal(data_tkeep[port], keep, $sformatf("tkeep on port %0d", port));
      check_equal(data_tlast[port], 1'b1, $sformatf("tlast on port %0d", port));
    end
    @(posedge clk);
    rx_tvalid[port] <= 1'b0;
    rx_tlast[port]  <= 1'b0;
    @(posedge clk);
    check_equal(beats - start_beats, 1, $sformatf("beats delivered on port %0d", port));
  endtask

  task automatic build_table();
    // Reset values and an unmapped address
    add_step(WB_READ, `SCHED_REG_ENABLE, 0, 32'h0);
    add_step(WB_READ, `SCHED_REG_INCOME, 0, 32'h0);
    add_step(WB_READ, 3, 0, `SCHED_BAD_READ);
    // Income is limited by the enabled mask
    add_step(WB_WRITE, `SCHED_REG_ENABLE, 32'h0F, 0);
    add_step(WB_WRITE, `SCHED_REG_INCOME, 32'hFF, 0);
    add_step(WB_READ, `SCHED_REG_INCOME, 0, 32'h0F);
    add_step(WB_WRITE, `SCHED_REG_ENABLE, 32'h0C, 0);
    add_step(WB_READ, `SCHED_REG_INCOME, 0, 32'h0C);
    add_step(WB_READ, `SCHED_REG_ENABLE, 0, 32'h0C);
    // Fill pools with no core taking income
    add_step(WB_WRITE, `SCHED_REG_INCOME, 32'h00, 0);
    add_step(WB_READ, `SCHED_REG_INCOME, 0, 32'h0);
    add_step(MSG_INIT, 2, 4, 0);
    add_step(MSG_INIT, 3, 3, 0);
    add_step(WB_READ, `SCHED_REG_CORE_BASE + 2, 0, 32'd4);
    add_step(WB_READ, `SCHED_REG_CORE_BASE + 3, 0, 32'd3);
    // Core 3 hands slots 1 to 3 out round-robin from port 0
    add_step(WB_WRITE, `SCHED_REG_INCOME, 32'h08, 0);
    add_step(WB_READ, `SCHED_REG_INCOME, 0, 32'h08);
    for (int p = 0; p < `SCHED_IF_COUNT; p++)
      add_step(WB_READ, `SCHED_REG_PORT_BASE + p, 0, port_word(ST_FIRST, 3, p + 1));
    add_step(WB_READ, `SCHED_REG_CORE_BASE + 3, 0, 32'd0);
    for (int p = 0; p < `SCHED_IF_COUNT; p++)
      add_step(PACKET, p, 0, desc_word(3, p + 1));
    for (int p = 0; p < `SCHED_IF_COUNT; p++)
      add_step(WB_READ, `SCHED_REG_PORT_BASE + p, 0, port_word(ST_STALL, 3, p + 1));
    // Returned slot goes straight to port 0 and meets back-pressure
    add_step(MSG_RETURN, 3, 9, 0);
    add_step(WB_READ, `SCHED_REG_PORT_BASE, 0, port_word(ST_FIRST, 3, 9));
    add_step(PACKET, 0, 4, desc_word(3, 9));
    add_step(WB_READ, `SCHED_REG_PORT_BASE, 0, port_word(ST_STALL, 3, 9));
    // Return and flush
    add_step(WB_WRITE, `SCHED_REG_INCOME, 32'h00, 0);
    add_step(MSG_INIT, 3, 2, 0);
    add_step(WB_READ, `SCHED_REG_CORE_BASE + 3, 0, 32'd2);
    add_step(MSG_RETURN, 2, 7, 0);
    add_step(WB_READ, `SCHED_REG_CORE_BASE + 2, 0, 32'd5);
    add_step(WB_WRITE, `SCHED_REG_FLUSH, 32'h04, 0);
    add_step(WB_READ, `SCHED_REG_CORE_BASE + 2, 0, 32'd0);
    add_step(WB_READ, `SCHED_REG_CORE_BASE + 3, 0, 32'd2);
  endtask

  initial begin
    void'($urandom(25392));
    clk            = 1'b0;
    rst_r          = 1'b1;
    rx_tdata       = '0;
    rx_tkeep       = '0;
    rx_tvalid      = '0;
    rx_tlast       = '0;
    data_tready    = '1;
    slot_msg_valid = 1'b0;
    slot_msg_init  = 1'b0;
    slot_msg_core  = '0;
    slot_msg_slot  = '0;
    wb_cyc         = 1'b0;
    wb_stb         = 1'b0;
    wb_we          = 1'b0;
    wb_adr         = '0;
    wb_dat_i       = '0;
    mismatches     = 0;
    timeouts       = 0;
    beats          = 0;
    build_table();

    repeat (16) @(posedge clk);
    rst_r <= 1'b0;
    @(negedge clk);
    check_equal(rx_tready, '0, "rx_tready after reset");
    check_equal(data_tvalid, '0, "data_tvalid after reset");
    check_equal(wb_ack, 1'b0, "wb_ack after reset");

    foreach (steps[i]) begin
      case (steps[i].kind)
        WB_WRITE:   wb_access(1'b1, 4'(steps[i].arg), steps[i].val, rdata);
        WB_READ: begin
          wb_access(1'b0, 4'(steps[i].arg), 32'h0, rdata);
          check_equal(rdata, steps[i].exp, $sformatf("read of address %0d", steps[i].arg));
        end
        MSG_INIT:   send_slot_msg(1'b1, steps[i].arg, steps[i].val);
        MSG_RETURN: send_slot_msg(1'b0, steps[i].arg, steps[i].val);
        default:    send_packet(steps[i].arg, steps[i].exp, steps[i].val);
      endcase
    end

    repeat (4) @(posedge clk);
    $display("Error counts: %0d mismatches, %0d timeouts", mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+.
sched_pkg.sv
sched_if.sv
slot_keeper.sv
slot_pool.sv
port_tracker.sv
desc_dispatch.sv
host_regs.sv
sched_top.sv
tb_sched_top.sv
